// File: kcpu_pkg.sv
// KCPU arithmetic unit definitions
package kcpu_pkg;

    localparam int DATA_W    = 16;                  // Operand and result width
    localparam int DIV_STEPS = 8;                   // Quotient bits per divide
    localparam int DIV_CNT_W = $clog2(DIV_STEPS);   // Divider step counter

    // Flag positions in the condition-code byte
    localparam int CC_C = 0;
    localparam int CC_V = 1;
    localparam int CC_Z = 2;
    localparam int CC_N = 3;
    localparam int CC_H = 5;

    // The decoder folds the CPU opcode space onto this list
    typedef enum logic [4:0] {
        OP_LD   = 5'd0,     // Load and test
        OP_ADD  = 5'd1,
        OP_ADC  = 5'd2,     // Add with carry
        OP_SUB  = 5'd3,
        OP_SBC  = 5'd4,     // Subtract with borrow
        OP_CMP  = 5'd5,     // Subtract, result discarded upstream
        OP_AND  = 5'd6,
        OP_EOR  = 5'd7,
        OP_OR   = 5'd8,
        OP_CLR  = 5'd9,
        OP_COM  = 5'd10,    // Ones complement
        OP_NEG  = 5'd11,    // Twos complement
        OP_INC  = 5'd12,
        OP_DEC  = 5'd13,
        OP_LSR  = 5'd14,
        OP_ROR  = 5'd15,    // Carry enters at the sign bit
        OP_ASR  = 5'd16,
        OP_ASL  = 5'd17,
        OP_ROL  = 5'd18,    // Carry enters at bit 0
        OP_DAA  = 5'd19,    // BCD fix after an add
        OP_SEX  = 5'd20,    // Sign extend low byte
        OP_MUL  = 5'd21,    // 8 by 8 unsigned
        OP_ABS  = 5'd22,
        OP_DIVU = 5'd23,    // 16 by 8 unsigned, multi-cycle
        OP_DIVS = 5'd24     // 16 by 8 signed, multi-cycle
    } alu_op_e;

    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,    // Waiting for start, loads operands
        DIV_RUN  = 2'd1,    // One quotient bit per step
        DIV_FIX  = 2'd2     // Sign correction
    } div_state_e;

endpackage

// File: kcpu_cc_if.sv
// Core result and flags
interface kcpu_cc_if;
    import kcpu_pkg::*;

    logic [DATA_W-1:0] rslt;
    logic              c;
    logic              v;
    logic              z;
    logic              n;
    logic              h;

    modport core (
        output rslt,
        output c,
        output v,
        output z,
        output n,
        output h
    );

    modport ctrl (
        input  rslt,
        input  c,
        input  v,
        input  z,
        input  n,
        input  h
    );

endinterface

// File: kcpu_div_if.sv
// Divider request and response
interface kcpu_div_if;
    import kcpu_pkg::*;

    logic              start;       // One enabled cycle
    logic [DATA_W-1:0] dividend;
    logic [7:0]        divisor;
    logic              sign;        // Signed divide
    logic [7:0]        quot;
    logic [7:0]        rem;
    logic              ovf;         // Zero divisor or quotient too wide
    logic              done;        // One enabled cycle

    modport ctrl (
        output start,
        output dividend,
        output divisor,
        output sign,
        input  quot,
        input  rem,
        input  ovf,
        input  done
    );

    modport div (
        input  start,
        input  dividend,
        input  divisor,
        input  sign,
        output quot,
        output rem,
        output ovf,
        output done
    );

endinterface

// File: kcpu_arith.sv
// KCPU single-cycle arithmetic core
module kcpu_arith (
    input  kcpu_pkg::alu_op_e           op,
    input  logic                        wide,
    input  logic [kcpu_pkg::DATA_W-1:0] opnd0,
    input  logic [kcpu_pkg::DATA_W-1:0] opnd1,
    input  logic [7:0]                  cc_in,
    kcpu_cc_if.core                     cc
);
    import kcpu_pkg::*;

    logic [3:0]        msb;         // Sign bit position
    logic [DATA_W-1:0] mask;        // Keeps bits of the selected width
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W:0]   sum;         // Adder output with carry bit
    logic [DATA_W-1:0] r;
    logic              c;
    logic              v;
    logic              h;
    logic [DATA_W-1:0] prod;
    logic              daa_lo;      // Low nibble needs +6
    logic              daa_hi;      // High nibble needs +6
    logic [8:0]        daa_sum;

    assign msb  = wide ? 4'd15 : 4'd7;
    assign mask = wide ? {DATA_W{1'b1}} : {{(DATA_W-8){1'b0}}, 8'hff};
    assign a    = opnd0 & mask;
    assign b    = opnd1 & mask;
    assign prod = opnd0[7:0] * opnd1[7:0];

    // Standard BCD correction, uses incoming C and H
    assign daa_lo  = cc_in[CC_H] | (opnd0[3:0] > 4'h9);
    assign daa_hi  = cc_in[CC_C] | (opnd0[7:4] > 4'h9) |
                     ((opnd0[7:4] > 4'h8) & (opnd0[3:0] > 4'h9));
    assign daa_sum = {1'b0, opnd0[7:0]} + {1'b0, daa_hi ? 4'h6 : 4'h0, daa_lo ? 4'h6 : 4'h0};

    always_comb begin
        c   = cc_in[CC_C];      // Undefined flags pass through
        v   = cc_in[CC_V];
        h   = cc_in[CC_H];
        sum = '0;
        r   = a;
        case (op)
            OP_LD: begin
                r = a;
                v = 1'b0;
            end
            OP_ADD, OP_ADC: begin
                sum = {1'b0, a} + {1'b0, b} + {{DATA_W{1'b0}}, (op == OP_ADC) & cc_in[CC_C]};
                r   = sum[DATA_W-1:0] & mask;
                c   = wide ? sum[16] : sum[8];
                v   = (a[msb] & b[msb] & ~r[msb]) | (~a[msb] & ~b[msb] & r[msb]);
                h   = a[4] ^ b[4] ^ r[4];   // Carry into bit 4
            end
            OP_SUB, OP_SBC, OP_CMP: begin
                sum = {1'b0, a} - {1'b0, b} - {{DATA_W{1'b0}}, (op == OP_SBC) & cc_in[CC_C]};
                r   = sum[DATA_W-1:0] & mask;
                c   = wide ? sum[16] : sum[8];  // Borrow
                v   = (a[msb] & ~b[msb] & ~r[msb]) | (~a[msb] & b[msb] & r[msb]);
            end
            OP_AND: begin
                r = a & b;
                v = 1'b0;
            end
            OP_EOR: begin
                r = a ^ b;
                v = 1'b0;
            end
            OP_OR: begin
                r = a | b;
                v = 1'b0;
            end
            OP_CLR: begin
                r = '0;
                c = 1'b0;
                v = 1'b0;
            end
            OP_COM: begin
                r = ~a & mask;
                c = 1'b1;
            end
            OP_NEG: begin
                r = (~a + 1'b1) & mask;
                c = (r != '0);
                v = (a[msb] == r[msb]);     // Zero and the most negative value
            end
            OP_INC: begin
                r = (a + 1'b1) & mask;
                v = ~a[msb] & r[msb];
            end
            OP_DEC: begin
                r = (a - 1'b1) & mask;
                v = a[msb] & ~r[msb];
            end
            OP_LSR: begin
                r = a >> 1;
                c = a[0];
            end
            OP_ROR: begin
                r      = a >> 1;
                r[msb] = cc_in[CC_C];
                c      = a[0];
            end
            OP_ASR: begin
                r      = a >> 1;
                r[msb] = a[msb];            // Keep sign
                c      = a[0];
            end
            OP_ASL: begin
                r = (a << 1) & mask;
                c = a[msb];
                v = a[msb] ^ r[msb];
            end
            OP_ROL: begin
                r = {a[DATA_W-2:0], cc_in[CC_C]} & mask;
                c = a[msb];
                v = a[msb] ^ r[msb];
            end
            OP_DAA: begin
                r = {{(DATA_W-8){1'b0}}, daa_sum[7:0]};
                c = cc_in[CC_C] | daa_sum[8];
            end
            OP_SEX: begin
                r = {{(DATA_W-8){opnd0[7]}}, opnd0[7:0]};
                v = 1'b0;
            end
            OP_MUL: begin
                r = prod;
                c = prod[7];                // Rounding bit for the high byte
            end
            OP_ABS: begin
                r = a[msb] ? ((~a + 1'b1) & mask) : a;
                c = 1'b0;
                v = 1'b0;
            end
            default: r = a;                 // Divides come from the divider
        endcase
    end

    assign cc.rslt = r;
    assign cc.c    = c;
    assign cc.v    = v;
    assign cc.h    = h;
    assign cc.z    = ((r & mask) == '0);
    assign cc.n    = r[msb];

endmodule

// File: kcpu_div.sv
// KCPU 16 by 8 restoring divider
module kcpu_div (
    input  logic    clk,
    input  logic    reset,
    input  logic    cen,
    kcpu_div_if.div dv
);
    import kcpu_pkg::*;

    div_state_e            state;
    logic [DIV_CNT_W-1:0]  cnt;         // Step counter
    logic [DATA_W-1:0]     n_mag;       // Dividend magnitude
    logic [7:0]            d_mag;       // Divisor magnitude
    logic [DATA_W:0]       q_lim;       // Smallest dividend that overflows
    logic                  q_neg;
    logic                  r_neg;
    logic [7:0]            d_r;
    logic [7:0]            rem_r;       // Partial remainder
    logic [7:0]            quo_r;       // Dividend low byte shifting out, quotient in
    logic                  q_neg_r;
    logic                  r_neg_r;
    logic [8:0]            acc;

    assign n_mag = (dv.sign && dv.dividend[15]) ? -dv.dividend : dv.dividend;
    assign d_mag = (dv.sign && dv.divisor[7]) ? -dv.divisor : dv.divisor;
    assign q_neg = dv.sign & (dv.dividend[15] ^ dv.divisor[7]);
    assign r_neg = dv.sign & dv.dividend[15];   // Remainder follows dividend

    // Unsigned up to 255, signed down to -128 and up to 127
    always_comb begin
        if (!dv.sign)
            q_lim = {1'b0, d_mag, 8'h00};
        else if (q_neg)
            q_lim = {2'b00, d_mag, 7'h00} + {9'h000, d_mag};
        else
            q_lim = {2'b00, d_mag, 7'h00};
    end

    assign acc = {rem_r, quo_r[7]};

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= DIV_IDLE;
            cnt     <= '0;
            dv.done <= 1'b0;
        end else if (cen) begin
            dv.done <= 1'b0;
            case (state)
                DIV_IDLE: begin
                    cnt <= '0;
                    if (dv.start)
                        state <= DIV_RUN;
                end
                DIV_RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == DIV_CNT_W'(DIV_STEPS - 1))
                        state <= DIV_FIX;
                end
                DIV_FIX: begin
                    state   <= DIV_IDLE;
                    dv.done <= 1'b1;
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            case (state)
                DIV_IDLE: if (dv.start) begin
                    rem_r   <= n_mag[15:8];
                    quo_r   <= n_mag[7:0];
                    d_r     <= d_mag;
                    q_neg_r <= q_neg;
                    r_neg_r <= r_neg;
                    dv.ovf  <= (d_mag == 8'h00) || ({1'b0, n_mag} >= q_lim);
                end
                DIV_RUN: begin
                    if (acc >= {1'b0, d_r}) begin
                        rem_r <= 8'(acc - {1'b0, d_r});
                        quo_r <= {quo_r[6:0], 1'b1};
                    end else begin
                        rem_r <= acc[7:0];  // Restore
                        quo_r <= {quo_r[6:0], 1'b0};
                    end
                end
                DIV_FIX: begin
                    dv.quot <= q_neg_r ? -quo_r : quo_r;
                    dv.rem  <= r_neg_r ? -rem_r : rem_r;
                end
                default: ;
            endcase
        end
    end

endmodule

// File: kcpu_alu_ctrl.sv
// KCPU ALU result controller
module kcpu_alu_ctrl (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        cen,
    input  logic                        op_valid,
    input  kcpu_pkg::alu_op_e           op,
    input  logic [kcpu_pkg::DATA_W-1:0] opnd0,
    input  logic [kcpu_pkg::DATA_W-1:0] opnd1,
    input  logic [7:0]                  cc_in,
    kcpu_cc_if.ctrl                     cc,
    kcpu_div_if.ctrl                    dv,
    output logic                        busy,
    output logic                        rslt_valid,
    output logic [kcpu_pkg::DATA_W-1:0] rslt,
    output logic                        c_out,
    output logic                        v_out,
    output logic                        z_out,
    output logic                        n_out,
    output logic                        h_out
);
    import kcpu_pkg::*;

    logic              is_div;
    logic              accept;
    logic [DATA_W-1:0] opnd_lat;    // Returned on divide overflow
    logic              h_lat;

    assign is_div = (op == OP_DIVU) || (op == OP_DIVS);
    assign accept = op_valid & ~busy;

    // Divider loads on the same edge that accepts the op
    assign dv.start    = cen & accept & is_div;
    assign dv.dividend = opnd0;
    assign dv.divisor  = opnd1[7:0];
    assign dv.sign     = (op == OP_DIVS);

    always_ff @(posedge clk) begin
        if (cen && accept && is_div) begin
            opnd_lat <= opnd0;
            h_lat    <= cc_in[CC_H];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            rslt_valid <= 1'b0;
            rslt       <= '0;
            c_out      <= 1'b0;
            v_out      <= 1'b0;
            z_out      <= 1'b0;
            n_out      <= 1'b0;
            h_out      <= 1'b0;
        end else if (cen) begin
            rslt_valid <= 1'b0;
            if (accept && is_div) begin
                busy <= 1'b1;
            end else if (accept) begin
                rslt_valid <= 1'b1;         // Single-cycle path
                rslt       <= cc.rslt;
                c_out      <= cc.c;
                v_out      <= cc.v;
                z_out      <= cc.z;
                n_out      <= cc.n;
                h_out      <= cc.h;
            end else if (busy && dv.done) begin
                busy       <= 1'b0;
                rslt_valid <= 1'b1;
                rslt       <= dv.ovf ? opnd_lat : {dv.rem, dv.quot};
                c_out      <= 1'b0;
                v_out      <= dv.ovf;
                z_out      <= ~dv.ovf & (dv.quot == 8'h00);
                n_out      <= ~dv.ovf & dv.quot[7];
                h_out      <= h_lat;
            end
        end
    end

endmodule

// File: kcpu_alu_unit.sv
// KCPU arithmetic unit top
module kcpu_alu_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        cen,
    input  logic                        op_valid,
    input  kcpu_pkg::alu_op_e           op,
    input  logic                        wide,
    input  logic [kcpu_pkg::DATA_W-1:0] opnd0,
    input  logic [kcpu_pkg::DATA_W-1:0] opnd1,
    input  logic [7:0]                  cc_in,
    output logic                        busy,
    output logic                        rslt_valid,
    output logic [kcpu_pkg::DATA_W-1:0] rslt,
    output logic                        c_out,
    output logic                        v_out,
    output logic                        z_out,
    output logic                        n_out,
    output logic                        h_out
);

    kcpu_cc_if  i_cc_if ();     // Core to controller
    kcpu_div_if i_div_if ();    // Controller to divider

    kcpu_arith i_kcpu_arith (
        .op    ( op       ),
        .wide  ( wide     ),
        .opnd0 ( opnd0    ),
        .opnd1 ( opnd1    ),
        .cc_in ( cc_in    ),
        .cc    ( i_cc_if  )
    );

    kcpu_div i_kcpu_div (
        .clk   ( clk      ),
        .reset ( reset    ),
        .cen   ( cen      ),
        .dv    ( i_div_if )
    );

    kcpu_alu_ctrl i_kcpu_alu_ctrl (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .cen        ( cen        ),
        .op_valid   ( op_valid   ),
        .op         ( op         ),
        .opnd0      ( opnd0      ),
        .opnd1      ( opnd1      ),
        .cc_in      ( cc_in      ),
        .cc         ( i_cc_if    ),
        .dv         ( i_div_if   ),
        .busy       ( busy       ),
        .rslt_valid ( rslt_valid ),
        .rslt       ( rslt       ),
        .c_out      ( c_out      ),
        .v_out      ( v_out      ),
        .z_out      ( z_out      ),
        .n_out      ( n_out      ),
        .h_out      ( h_out      )
    );

endmodule

// File: tb_kcpu_alu_unit.sv
// KCPU arithmetic unit testbench
module tb_kcpu_alu_unit;
    import kcpu_pkg::*;

    localparam int N_VEC   = 24;
    localparam int FIELDS  = 7;                             // Words per trace line
    localparam int TIMEOUT = N_VEC * (DIV_STEPS + 20) + 100;

    logic              clk;
    logic              reset;
    logic              cen;
    logic              op_valid;
    alu_op_e           op;
    logic              wide;
    logic [DATA_W-1:0] opnd0;
    logic [DATA_W-1:0] opnd1;
    logic [7:0]        cc_in;
    logic              busy;
    logic              rslt_valid;
    logic [DATA_W-1:0] rslt;
    logic              c_out;
    logic              v_out;
    logic              z_out;
    logic              n_out;
    logic              h_out;
    logic [15:0]       trace_mem [N_VEC*FIELDS];
    logic [31:0]       rng;
    int                gap_len;                             // Low-cen cycles in first divide
    int                cycles = 0;
    int                rslt_errs;
    int                flag_errs;
    int                ctl_errs;

    kcpu_alu_unit i_kcpu_alu_unit (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .cen        ( cen        ),
        .op_valid   ( op_valid   ),
        .op         ( op         ),
        .wide       ( wide       ),
        .opnd0      ( opnd0      ),
        .opnd1      ( opnd1      ),
        .cc_in      ( cc_in      ),
        .busy       ( busy       ),
        .rslt_valid ( rslt_valid ),
        .rslt       ( rslt       ),
        .c_out      ( c_out      ),
        .v_out      ( v_out      ),
        .z_out      ( z_out      ),
        .n_out      ( n_out      ),
        .h_out      ( h_out      )
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    function automatic logic [7:0] packed_cc();
        logic [7:0] f;
        f       = '0;
        f[CC_C] = c_out;
        f[CC_V] = v_out;
        f[CC_Z] = z_out;
        f[CC_N] = n_out;
        f[CC_H] = h_out;
        return f;
    endfunction

    task automatic check_rslt(input logic [DATA_W-1:0] got, exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s rslt %h, expected %h", $time, what, got, exp);
            rslt_errs++;
        end
    endtask

    task automatic check_flags(input logic [7:0] got, exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s flags %h, expected %h", $time, what, got, exp);
            flag_errs++;
        end
    endtask

    task automatic check_op_busy(input logic got, exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s busy %b, expected %b", $time, what, got, exp);
            ctl_errs++;
        end
    endtask

    task automatic check_valid(input logic got, exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s rslt_valid %b, expected %b", $time, what, got, exp);
            ctl_errs++;
        end
    endtask

    task automatic check_latency(input int got, exp, input string what);
        if (got != exp) begin
            $display("CHECK FAILED at %0t: %s took %0d enabled clocks, expected %0d",
                     $time, what, got, exp);
            ctl_errs++;
        end
    endtask

    // Entered and left 10 units after a rising edge
    task automatic run_vector(input int idx);
        int    base;
        int    k;
        int    enabled;
        int    gap;
        logic  is_div;
        logic  cen_now;
        string tag;
        base     = idx * FIELDS;
        op       = alu_op_e'(trace_mem[base][4:0]);
        wide     = trace_mem[base+1][0];
        opnd0    = trace_mem[base+2];
        opnd1    = trace_mem[base+3];
        cc_in    = trace_mem[base+4][7:0];
        op_valid = 1'b1;
        is_div   = (op == OP_DIVU) || (op == OP_DIVS);
        gap      = is_div ? gap_len : 0;
        if (is_div)
            gap_len = 0;
        tag = $sformatf("vector %0d %s", idx, op.name());
        @(posedge clk);
        #10;
        op_valid = 1'b0;
        check_op_busy(busy, is_div, tag);
        k       = 0;
        enabled = 0;
        while (!rslt_valid) begin
            cen      = !(k >= 3 && k < 3 + gap);            // Scripted cen gap
            op_valid = is_div && (k == 1);                  // Strobe while busy
            if (op_valid) begin
                op    = OP_LD;                              // Inputs move on while busy
                opnd0 = ~opnd0;
                cc_in = ~cc_in;
            end
            cen_now  = cen;
            @(posedge clk);
            #10;
            if (cen_now)
                enabled++;
            k++;
        end
        cen      = 1'b1;
        op_valid = 1'b0;
        check_latency(enabled, is_div ? DIV_STEPS + 2 : 0, tag);
        check_rslt(rslt, trace_mem[base+5], tag);
        check_flags(packed_cc(), trace_mem[base+6][7:0], tag);
        check_op_busy(busy, 1'b0, tag);
        @(posedge clk);
        #10;
        check_valid(rslt_valid, 1'b0, tag);                 // No second pulse
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        reset     = 1'b1;
        cen       = 1'b1;
        op_valid  = 1'b0;
        op        = OP_LD;
        wide      = 1'b0;
        opnd0     = '0;
        opnd1     = '0;
        cc_in     = '0;
        rslt_errs = 0;
        flag_errs = 0;
        ctl_errs  = 0;
        rng       = xorshift32(32'd17073);
        gap_len   = 1 + int'(rng % 5);
        $readmemh("kcpu_alu_trace.txt", trace_mem);
        if ($isunknown(trace_mem[N_VEC*FIELDS-1])) begin
            $display("Trace file is missing or holds fewer than %0d operations", N_VEC);
            ctl_errs++;
        end
        repeat (5) @(posedge clk);
        #10;
        reset = 1'b0;
        check_op_busy(busy, 1'b0, "after reset");
        check_valid(rslt_valid, 1'b0, "after reset");
        check_rslt(rslt, '0, "after reset");
        check_flags(packed_cc(), 8'h00, "after reset");
        for (int i = 0; i < N_VEC; i++)
            run_vector(i);
        $display("Errors: result %0d, flags %0d, control %0d", rslt_errs, flag_errs, ctl_errs);
        if (rslt_errs + flag_errs + ctl_errs == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: kcpu_alu_trace.txt
// op wide opnd0 opnd1 cc_in rslt cc in hex, one operation per line
// cc holds the expected flags as H=5 N=3 Z=2 V=1 C=0 with other bits zero
01 0 1248 0038 00 0080 2A // ADD 8-bit with overflow and half carry
02 1 FFFF 0000 01 0000 25 // ADC 16-bit carry in and out
03 0 0010 0020 00 00F0 09 // SUB 8-bit borrow
04 1 8000 0001 01 7FFE 02 // SBC 16-bit overflow
05 0 0042 0042 20 0000 24 // CMP equal keeps H
06 0 00F0 0F0F 03 0000 05 // AND clears V and keeps C
09 0 0055 0000 2B 0000 24 // CLR
0A 1 00FF 0000 00 FF00 09 // COM 16-bit
0B 0 0080 0000 00 0080 0B // NEG of most negative value
0C 0 007F 0000 00 0080 0A // INC overflow
0D 1 0001 0000 01 0000 05 // DEC to zero
00 1 8001 0000 02 8001 08 // LD clears V
14 1 12F0 0000 00 FFF0 08 // SEX
16 0 00FE 0000 03 0002 00 // ABS
0E 0 0081 0000 00 0040 01 // LSR
0F 0 0002 0000 01 0081 08 // ROR with carry in
11 1 4000 0000 00 8000 0A // ASL 16-bit
12 0 0080 0000 01 0001 03 // ROL with carry in
13 0 009A 0000 00 0000 05 // DAA with carry out
15 1 0030 0045 00 0CF0 01 // MUL
17 0 1234 0056 20 1036 20 // DIVU
18 0 FF00 0007 00 FCDC 08 // DIVS negative dividend
17 0 1234 0000 01 1234 02 // DIVU by zero
18 0 7FFF 0001 20 7FFF 22 // DIVS quotient overflow

// File: sim.f
kcpu_pkg.sv
kcpu_cc_if.sv
kcpu_div_if.sv
kcpu_arith.sv
kcpu_div.sv
kcpu_alu_ctrl.sv
kcpu_alu_unit.sv
tb_kcpu_alu_unit.sv

// File: Bender.yml
package:
  name: kcpu_alu

sources:
  - kcpu_pkg.sv
  - kcpu_cc_if.sv
  - kcpu_div_if.sv
  - kcpu_arith.sv
  - kcpu_div.sv
  - kcpu_alu_ctrl.sv
  - kcpu_alu_unit.sv
  - target: test
    files:
      - tb_kcpu_alu_unit.sv
